// File: sources.f
+incdir+include
rtl/udp_echo_pkg.sv
rtl/udp_stream_if.sv
rtl/udp_port_filter.sv
rtl/udp_reply_builder.sv
rtl/frame_fifo.sv
rtl/udp_echo_top.sv
dv/udp_echo_sva.sv
dv/udp_echo_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the UDP echo testbench with Verilator.
# The run fails when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module udp_echo_tb -f sources.f -o udp_echo_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/udp_echo_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
  exit 1
fi
exit 0

// File: dv/udp_echo_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for udp_echo_top. Random frames, about a quarter
// of them for other ports, under random tx back-pressure.
// Replies are checked against queues built from the echo
// rules. Handshake and reset checks sit in the bound SVA.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_echo_tb
  import udp_echo_pkg::*;
();

  localparam int          BURSTS     = 6;
  localparam int          BURST_LEN  = 8;
  localparam int          WAIT_LIMIT = 400;
  localparam logic [31:0] SEED       = 32'd25;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0180;
  localparam logic [15:0] PORT       = 16'(`UDP_ECHO_DEFAULT_PORT);

  logic        clk;
  logic        rst;
  logic        rx_hdr_valid;
  logic        rx_hdr_ready;
  udp_hdr_t    rx_hdr;
  logic        rx_beat_valid;
  logic        rx_beat_ready;
  axis_beat_t  rx_beat;
  logic        tx_hdr_valid;
  logic        tx_hdr_ready;
  udp_hdr_t    tx_hdr;
  logic        tx_beat_valid;
  logic        tx_beat_ready;
  axis_beat_t  tx_beat;
  logic [7:0]  led;
  logic [7:0]  last_led;
  logic [31:0] rng;
  logic [31:0] tx_rng;
  logic        aborted;
  int          errors;
  int          sva_errors;
  udp_hdr_t    exp_hdr_q [$];
  axis_beat_t  exp_beat_q [$];

  udp_echo_top dut (
    .clk (clk), .rst (rst), .udp_port (PORT), .local_ip (LOCAL_IP),
    .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
    .rx_src_ip (rx_hdr.src_ip), .rx_dst_ip (rx_hdr.dst_ip),
    .rx_src_port (rx_hdr.src_port), .rx_dst_port (rx_hdr.dst_port),
    .rx_length (rx_hdr.length), .rx_ttl (rx_hdr.ttl), .rx_checksum (rx_hdr.checksum),
    .rx_beat_valid (rx_beat_valid), .rx_beat_ready (rx_beat_ready),
    .rx_data (rx_beat.data), .rx_keep (rx_beat.keep),
    .rx_last (rx_beat.last), .rx_user (rx_beat.user),
    .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready),
    .tx_src_ip (tx_hdr.src_ip), .tx_dst_ip (tx_hdr.dst_ip),
    .tx_src_port (tx_hdr.src_port), .tx_dst_port (tx_hdr.dst_port),
    .tx_length (tx_hdr.length), .tx_ttl (tx_hdr.ttl), .tx_checksum (tx_hdr.checksum),
    .tx_beat_valid (tx_beat_valid), .tx_beat_ready (tx_beat_ready),
    .tx_data (tx_beat.data), .tx_keep (tx_beat.keep),
    .tx_last (tx_beat.last), .tx_user (tx_beat.user),
    .led (led)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [135:0] got,
                             input logic [135:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Called for each tx transfer seen just before the clock edge
  task automatic check_hdr_xfer();
    assert (exp_hdr_q.size() != 0) else begin
      errors++;
      $display("A tx header came out while no reply header was due");
    end
    if (exp_hdr_q.size() != 0)
      check_value("tx_hdr", 136'(tx_hdr), 136'(exp_hdr_q.pop_front()));
  endtask

  task automatic check_beat_xfer();
    assert (exp_beat_q.size() != 0) else begin
      errors++;
      $display("A tx beat came out while no reply beat was due");
    end
    if (exp_beat_q.size() != 0)
      check_value("tx_beat", 136'(tx_beat), 136'(exp_beat_q.pop_front()));
  endtask

  task automatic send_frame();
    udp_hdr_t   hdr;
    udp_hdr_t   reply;
    axis_beat_t beats [6];
    int         n;
    int         i;
    int         sent;
    int         cycles;
    logic       match;
    logic       hdr_done;
    logic       hdr_now;
    logic       beat_now;
    rng = xorshift32(rng);
    n = 1 + int'(rng % 32'd6);
    match = (rng[9:8] != 2'b00);
    rng = xorshift32(rng);
    hdr.src_ip = rng;
    hdr.dst_ip = LOCAL_IP;
    rng = xorshift32(rng);
    hdr.src_port = rng[15:0];
    hdr.dst_port = match ? PORT : PORT + 16'(rng[27:24]) + 16'd1;
    hdr.length = 16'(8 + 8 * n);
    hdr.ttl = rng[23:16];
    hdr.checksum = {rng[31:28], rng[11:0]};
    for (i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      beats[i].data[63:32] = rng;
      rng = xorshift32(rng);
      beats[i].data[31:0] = rng;
      beats[i].keep = (i == n - 1) ? (8'hff >> rng[2:0]) : 8'hff;
      beats[i].last = (i == n - 1);
      beats[i].user = rng[3];
    end
    // Reply as the echo rules define it
    if (match) begin
      reply = '{LOCAL_IP, hdr.src_ip, hdr.dst_port, hdr.src_port, hdr.length,
                8'(`UDP_ECHO_REPLY_TTL), 16'h0000};
      exp_hdr_q.push_back(reply);
      for (i = 0; i < n; i++)
        exp_beat_q.push_back(beats[i]);
      last_led = beats[0].data[7:0];
    end
    @(negedge clk);
    rx_hdr = hdr;
    rx_hdr_valid = 1'b1;
    rx_beat = beats[0];
    rx_beat_valid = 1'b1;
    sent = 0;
    hdr_done = 1'b0;
    cycles = 0;
    while (!(hdr_done && sent == n) && cycles < WAIT_LIMIT) begin
      #1;
      hdr_now = rx_hdr_valid && rx_hdr_ready;
      beat_now = rx_beat_valid && rx_beat_ready;
      @(negedge clk);
      cycles++;
      if (hdr_now) begin
        hdr_done = 1'b1;
        rx_hdr_valid = 1'b0;
      end
      if (beat_now) begin
        sent++;
        if (sent == n)
          rx_beat_valid = 1'b0;
        else
          rx_beat = beats[sent];
      end
    end
    if (!(hdr_done && sent == n)) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: rx frame not taken, header %0d, %0d of %0d beats", hdr_done, sent, n);
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: %0d reply headers and %0d reply beats never came out",
               exp_hdr_q.size(), exp_beat_q.size());
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Random tx readies, and a check of every tx transfer
  initial begin
    tx_hdr_ready = 1'b0;
    tx_beat_ready = 1'b0;
    tx_rng = ~SEED;
    forever begin
      @(negedge clk);
      tx_rng = xorshift32(tx_rng);
      tx_hdr_ready = tx_rng[0];
      tx_beat_ready = tx_rng[1] | tx_rng[2];
      #1;
      if (tx_hdr_valid && tx_hdr_ready)
        check_hdr_xfer();
      if (tx_beat_valid && tx_beat_ready)
        check_beat_xfer();
    end
  end

  initial begin
    rst = 1'b1;
    rx_hdr_valid = 1'b0;
    rx_hdr = '0;
    rx_beat_valid = 1'b0;
    rx_beat = '0;
    rng = SEED;
    last_led = 8'h00;
    aborted = 1'b0;
    errors = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int b = 0; b < BURSTS; b++) begin
      for (int f = 0; f < BURST_LEN; f++)
        if (!aborted)
          send_frame();
      if (!aborted)
        wait_drained();
      // Path is empty, so led shows the latest reply
      if (!aborted)
        check_value("led", 136'(led), 136'(last_led));
    end
    repeat (10) @(negedge clk);
    sva_errors = dut.echo_checks.fail_count;
    $display("Errors: %0d testbench, %0d assertion", errors, sva_errors);
    if (errors == 0 && sva_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: dv/udp_echo_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol and echo checks bound into udp_echo_top.
// Failures go to $error and are tallied in fail_count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_echo_sva
  import udp_echo_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic [31:0] local_ip,
  input logic        tx_hdr_valid,
  input logic        tx_hdr_ready,
  input udp_hdr_t    tx_hdr,
  input logic        tx_beat_valid,
  input logic        tx_beat_ready,
  input axis_beat_t  tx_beat,
  input logic [7:0]  led
);

  int fail_count = 0;

  // A stalled output keeps valid and data
  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
    else begin
      $error("tx header dropped or changed while stalled");
      fail_count++;
    end

  beat_hold: assert property (@(posedge clk) disable iff (rst)
    tx_beat_valid && !tx_beat_ready |=> tx_beat_valid && $stable(tx_beat))
    else begin
      $error("tx beat dropped or changed while stalled");
      fail_count++;
    end

  // Fields that every reply carries
  reply_fixed: assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid |-> tx_hdr.src_ip == local_ip && tx_hdr.checksum == 16'h0000 &&
                     tx_hdr.ttl == 8'(`UDP_ECHO_REPLY_TTL))
    else begin
      $error("tx header with wrong source IP, TTL or checksum");
      fail_count++;
    end

  // Quiet from the first reset edge through the cycle after reset
  reset_quiet: assert property (@(posedge clk)
    rst |=> !tx_hdr_valid && !tx_beat_valid && led == 8'h00)
    else begin
      $error("tx valid or led active during or right after reset");
      fail_count++;
    end

endmodule

bind udp_echo_top udp_echo_sva echo_checks (
  .clk           (clk),
  .rst           (rst),
  .local_ip      (local_ip),
  .tx_hdr_valid  (tx_hdr_valid),
  .tx_hdr_ready  (tx_hdr_ready),
  .tx_hdr        (tx_hdr),
  .tx_beat_valid (tx_beat_valid),
  .tx_beat_ready (tx_beat_ready),
  .tx_beat       (tx_beat),
  .led           (led)
);

// File: rtl/udp_echo_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UDP echo path through port filter, reply builder and FIFOs.
// Two cycles from an rx header to tx_hdr_valid when idle.
// Frames for other ports are dropped without notice.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_echo_top
  import udp_echo_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic [15:0]                     udp_port,
  input  logic [31:0]                     local_ip,
  // Received headers
  input  logic                            rx_hdr_valid,
  output logic                            rx_hdr_ready,
  input  logic [31:0]                     rx_src_ip,
  input  logic [31:0]                     rx_dst_ip,
  input  logic [15:0]                     rx_src_port,
  input  logic [15:0]                     rx_dst_port,
  input  logic [15:0]                     rx_length,
  input  logic [7:0]                      rx_ttl,
  input  logic [15:0]                     rx_checksum,
  // Received payload
  input  logic                            rx_beat_valid,
  output logic                            rx_beat_ready,
  input  logic [`UDP_ECHO_DATA_WIDTH-1:0] rx_data,
  input  logic [`UDP_ECHO_KEEP_WIDTH-1:0] rx_keep,
  input  logic                            rx_last,
  input  logic                            rx_user,
  // Reply headers
  output logic                            tx_hdr_valid,
  input  logic                            tx_hdr_ready,
  output logic [31:0]                     tx_src_ip,
  output logic [31:0]                     tx_dst_ip,
  output logic [15:0]                     tx_src_port,
  output logic [15:0]                     tx_dst_port,
  output logic [15:0]                     tx_length,
  output logic [7:0]                      tx_ttl,
  output logic [15:0]                     tx_checksum,
  // Reply payload
  output logic                            tx_beat_valid,
  input  logic                            tx_beat_ready,
  output logic [`UDP_ECHO_DATA_WIDTH-1:0] tx_data,
  output logic [`UDP_ECHO_KEEP_WIDTH-1:0] tx_keep,
  output logic                            tx_last,
  output logic                            tx_user,
  output logic [7:0]                      led
);

  udp_stream_if rx_if ();
  udp_stream_if flt_if ();

  logic       bld_hdr_valid;
  logic       bld_hdr_ready;
  udp_hdr_t   bld_hdr;
  logic       bld_beat_valid;
  logic       bld_beat_ready;
  axis_beat_t bld_beat;
  udp_hdr_t   tx_hdr;
  axis_beat_t tx_beat;

  // Pack rx ports into the stream
  assign rx_if.hdr_valid  = rx_hdr_valid;
  assign rx_if.hdr        = '{rx_src_ip, rx_dst_ip, rx_src_port, rx_dst_port,
                              rx_length, rx_ttl, rx_checksum};
  assign rx_hdr_ready     = rx_if.hdr_ready;
  assign rx_if.beat_valid = rx_beat_valid;
  assign rx_if.beat       = '{rx_data, rx_keep, rx_last, rx_user};
  assign rx_beat_ready    = rx_if.beat_ready;

  udp_port_filter port_filter (
    .clk      (clk),
    .rst      (rst),
    .udp_port (udp_port),
    .in       (rx_if),
    .out      (flt_if)
  );

  udp_reply_builder reply_builder (
    .clk            (clk),
    .rst            (rst),
    .local_ip       (local_ip),
    .in             (flt_if),
    .hdr_out_valid  (bld_hdr_valid),
    .hdr_out_ready  (bld_hdr_ready),
    .hdr_out        (bld_hdr),
    .beat_out_valid (bld_beat_valid),
    .beat_out_ready (bld_beat_ready),
    .beat_out       (bld_beat),
    .led            (led)
  );

  frame_fifo #(.payload_t(udp_hdr_t)) hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (bld_hdr_valid),
    .in_ready  (bld_hdr_ready),
    .in_data   (bld_hdr),
    .out_valid (tx_hdr_valid),
    .out_ready (tx_hdr_ready),
    .out_data  (tx_hdr)
  );

  frame_fifo #(.payload_t(axis_beat_t)) beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (bld_beat_valid),
    .in_ready  (bld_beat_ready),
    .in_data   (bld_beat),
    .out_valid (tx_beat_valid),
    .out_ready (tx_beat_ready),
    .out_data  (tx_beat)
  );

  // Unpack FIFO outputs onto tx ports
  assign {tx_src_ip, tx_dst_ip, tx_src_port, tx_dst_port,
          tx_length, tx_ttl, tx_checksum} = tx_hdr;
  assign {tx_data, tx_keep, tx_last, tx_user} = tx_beat;

endmodule

// File: rtl/frame_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shift-register FIFO for any packed payload type.
// depth must be 2 or more. in_ready is low while full, even
// when a read happens in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module frame_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = `UDP_ECHO_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int IDX_W = $clog2(depth);
  localparam int CNT_W = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_m1;
  logic [IDX_W-1:0] rd_idx;
  logic             wr;
  logic             rd;

  assign in_ready  = (count != CNT_W'(depth));
  assign out_valid = (count != '0);
  assign wr        = in_valid && in_ready;
  assign rd        = out_valid && out_ready;

  // Oldest entry sits at count - 1
  assign count_m1 = count - 1'b1;
  assign rd_idx   = out_valid ? count_m1[IDX_W-1:0] : '0;
  assign out_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[0] <= in_data;
      for (int i = 1; i < depth; i++)
        mem[i] <= mem[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      count <= '0;
    else if (wr && !rd)
      count <= count + 1'b1;
    else if (rd && !wr)
      count <= count - 1'b1;
  end

endmodule

// File: rtl/udp_reply_builder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One register per channel on the reply path, with no bubbles.
// Reply checksum is always zero (no checksum generation).
// led holds the low byte of the latest reply's first beat.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_reply_builder
  import udp_echo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] local_ip,
  udp_stream_if.snk   in,
  output logic        hdr_out_valid,
  input  logic        hdr_out_ready,
  output udp_hdr_t    hdr_out,
  output logic        beat_out_valid,
  input  logic        beat_out_ready,
  output axis_beat_t  beat_out,
  output logic [7:0]  led
);

  logic first_beat;

  // Take new input when empty or draining this cycle
  assign in.hdr_ready  = !hdr_out_valid || hdr_out_ready;
  assign in.beat_ready = !beat_out_valid || beat_out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_out_valid  <= 1'b0;
      beat_out_valid <= 1'b0;
      first_beat     <= 1'b1;
      led            <= 8'h00;
    end else begin
      if (in.hdr_ready)
        hdr_out_valid <= in.hdr_valid;
      if (in.beat_ready)
        beat_out_valid <= in.beat_valid;
      // Next beat after a last one starts a new frame
      if (beat_out_valid && beat_out_ready) begin
        first_beat <= beat_out.last;
        if (first_beat)
          led <= beat_out.data[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in.hdr_valid && in.hdr_ready) begin
      hdr_out.src_ip   <= local_ip;
      hdr_out.dst_ip   <= in.hdr.src_ip;
      hdr_out.src_port <= in.hdr.dst_port;
      hdr_out.dst_port <= in.hdr.src_port;
      hdr_out.length   <= in.hdr.length;
      hdr_out.ttl      <= 8'(`UDP_ECHO_REPLY_TTL);
      hdr_out.checksum <= 16'h0000;
    end
    // Payload is echoed untouched
    if (in.beat_valid && in.beat_ready)
      beat_out <= in.beat;
  end

endmodule

// File: rtl/udp_port_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Destination port filter with one frame in flight at a time.
// Beats are held back until the frame header is decided.
// Dropped frames are consumed here at full rate.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_port_filter (
  input  logic         clk,
  input  logic         rst,
  input  logic [15:0]  udp_port,
  udp_stream_if.snk    in,
  udp_stream_if.src    out
);

  logic decided;
  logic pass;
  logic match;
  logic hdr_xfer;
  logic last_xfer;

  assign match = (in.hdr.dst_port == udp_port);

  // Header side opens only while no frame is pending
  assign out.hdr_valid = in.hdr_valid && !decided && match;
  assign out.hdr       = in.hdr;
  assign in.hdr_ready  = !decided && (match ? out.hdr_ready : 1'b1);

  // Beat side opens once the header is decided
  assign out.beat_valid = in.beat_valid && decided && pass;
  assign out.beat       = in.beat;
  assign in.beat_ready  = decided && (pass ? out.beat_ready : 1'b1);

  assign hdr_xfer  = in.hdr_valid && in.hdr_ready;
  assign last_xfer = in.beat_valid && in.beat_ready && in.beat.last;

  // Per-frame decision
  always_ff @(posedge clk) begin
    if (rst) begin
      decided <= 1'b0;
      pass    <= 1'b0;
    end else if (hdr_xfer) begin
      decided <= 1'b1;
      pass    <= match;
    end else if (last_xfer) begin
      decided <= 1'b0;
      pass    <= 1'b0;
    end
  end

endmodule

// File: rtl/udp_stream_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A UDP frame stream carries a header channel and a beat channel.
// Each channel moves on valid and ready both high; a raised
// valid holds with stable data until it moves.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface udp_stream_if
  import udp_echo_pkg::*;
();

  // Header channel
  logic       hdr_valid;
  logic       hdr_ready;
  udp_hdr_t   hdr;

  // Payload channel
  logic       beat_valid;
  logic       beat_ready;
  axis_beat_t beat;

  modport src (
    output hdr_valid, hdr, beat_valid, beat,
    input  hdr_ready, beat_ready
  );

  modport snk (
    input  hdr_valid, hdr, beat_valid, beat,
    output hdr_ready, beat_ready
  );

endinterface

// File: rtl/udp_echo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header and beat types of the UDP echo path.
// Holds the UDP view only, with no MAC or IP option fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "udp_echo_settings.svh"

package udp_echo_pkg;

  // UDP header with the IP fields the echo path needs
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [7:0]  ttl;
    logic [15:0] checksum;
  } udp_hdr_t;

  // One payload beat in AXI stream style
  typedef struct packed {
    logic [`UDP_ECHO_DATA_WIDTH-1:0] data;
    logic [`UDP_ECHO_KEEP_WIDTH-1:0] keep;
    logic                            last;
    logic                            user;
  } axis_beat_t;

endpackage

// File: include/udp_echo_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build settings for the UDP echo path.
// KEEP_WIDTH must equal DATA_WIDTH / 8.
// FIFO depth must be 2 or more.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Payload beat width and its byte enables
`define UDP_ECHO_DATA_WIDTH 64
`define UDP_ECHO_KEEP_WIDTH 8

// Entries in each transmit FIFO
`define UDP_ECHO_FIFO_DEPTH 4

// IP TTL placed in every reply
`define UDP_ECHO_REPLY_TTL 64

// Default listening port, driven by the testbench
`define UDP_ECHO_DEFAULT_PORT 1234

`endif
